//--- verilog.f
verilog/dmem_pkg.sv
verilog/dmem_req_fifo.sv
verilog/dmem_access_chk.sv
verilog/dmem_ext_if.sv
verilog/dmem_ctrl.sv
bench/dmem_ext_if_props.sv
bench/dmem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf build
verilator --binary --assert -j 0 \
  --top-module dmem_tb \
  -Mdir build \
  -f verilog.f

./build/Vdmem_tb | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

grep -q "All checks passed" sim.log
echo "Simulation PASSED"

//--- bench/dmem_tb.sv
// Bus model serves one strobe at a time; st_prv_i is only changed with the request queue drained
`timescale 1ns/10ps

module dmem_tb;

  import dmem_pkg::*;

  localparam int          DEPTH          = 2;
  localparam int          PMA_CNT        = 3;
  localparam int          REQ_BUDGET     = 300;  // Upper bound on requests in the run
  localparam int          CYCLES_PER_REQ = 40;   // Worst case bus delays plus queue wait
  localparam int          MAX_CYCLES     = REQ_BUDGET * CYCLES_PER_REQ;
  localparam logic [31:0] BUSERR_ADDR    = 32'h0000_0FF0;  // Bus answers with an error here

  typedef enum logic [1:0] {KIND_ACK, KIND_ERR, KIND_MIS, KIND_BUSERR} kind_t;

  typedef struct packed {
    kind_t       kind;
    logic [31:0] data;   // Read data, only for loads that complete
  } expect_t;

  logic                 clk_i;
  logic                 rst_n_i;
  pma_region_t          pma_cfg [PMA_CNT];
  logic                 mem_req_i;
  dmem_req_t            mem_req_i_data;
  logic                 mem_rdy_o;
  logic [DMEM_XLEN-1:0] mem_q_o;
  logic                 mem_ack_o;
  logic                 mem_err_o;
  logic                 mem_misaligned_o;
  logic [1:0]           st_prv_i;
  logic                 biu_stb_o;
  biu_req_t             biu_req_o;
  logic                 biu_stb_ack_i;
  logic [DMEM_XLEN-1:0] biu_q_i;
  logic                 biu_ack_i;
  logic                 biu_err_i;

  int          seed;
  int          errors;
  int          checks;
  int          responses;
  int          discarded;            // Requests dropped by a flush
  int          rdy_low;              // Cycles with the queue full
  int          cycles;
  dmem_req_t   pending [$];          // Accepted, not yet answered, oldest first
  logic [31:0] shadow_mem [logic [29:0]];
  logic [31:0] bus_mem [logic [29:0]];

  dmem_ctrl #(
    .DEPTH   ( DEPTH   ),
    .PMA_CNT ( PMA_CNT )
  )
  dmem_ctrl_i (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .pma_cfg_i        ( pma_cfg          ),
    .mem_req_i        ( mem_req_i        ),
    .mem_req_i_data   ( mem_req_i_data   ),
    .mem_rdy_o        ( mem_rdy_o        ),
    .mem_q_o          ( mem_q_o          ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o ),
    .st_prv_i         ( st_prv_i         ),
    .biu_stb_o        ( biu_stb_o        ),
    .biu_req_o        ( biu_req_o        ),
    .biu_stb_ack_i    ( biu_stb_ack_i    ),
    .biu_q_i          ( biu_q_i          ),
    .biu_ack_i        ( biu_ack_i        ),
    .biu_err_i        ( biu_err_i        )
  );

  bind dmem_ext_if dmem_ext_if_props props_i (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .head_valid_i     ( head_valid_i     ),
    .check_err_i      ( check_err_i      ),
    .biu_stb_o        ( biu_stb_o        ),
    .biu_req_o        ( biu_req_o        ),
    .biu_stb_ack_i    ( biu_stb_ack_i    ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic flag_problem(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic tick();
    @(posedge clk_i);
    #1;                                // Drive and sample clear of the edge
  endtask

  function automatic pma_region_t region(input logic [31:0] lo, input logic [31:0] hi,
                                         input logic rd, input logic wr);
    pma_region_t r;
    r.valid    = 1'b1;
    r.lo       = lo;
    r.hi       = hi;
    r.readable = rd;
    r.writable = wr;
    return r;
  endfunction

  // Unwritten words, every address bit above the lanes counts
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'hC3A5_5A3C;
  endfunction

  function automatic logic [31:0] read_shadow(input logic [31:0] addr);
    if (shadow_mem.exists(addr[31:2]))
      return shadow_mem[addr[31:2]];
    return fill_word(addr);
  endfunction

  // Store data sits in its own lanes, no shifting on the bus
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [31:0] addr, input biu_size_t size);
    logic [3:0]  be;
    logic [31:0] res;
    case (size)
      BYTE:    be = 4'b0001 << addr[1:0];
      HWORD:   be = 4'b0011 << addr[1:0];
      default: be = 4'b1111;
    endcase
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (be[i])
        res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  // Expected outcome of one access
  function automatic expect_t ref_model(input logic [31:0] addr, input biu_size_t size,
                                        input logic we, input pma_region_t regions [PMA_CNT]);
    expect_t e;
    logic    found;
    logic    allowed;
    e.kind  = KIND_ACK;
    e.data  = read_shadow(addr);
    found   = 1'b0;
    allowed = 1'b0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      if (!found && regions[i].valid && addr >= regions[i].lo && addr <= regions[i].hi)
      begin
        found   = 1'b1;                // First matching region decides
        allowed = we ? regions[i].writable : regions[i].readable;
      end
    end
    if ((size == HWORD && addr[0]) || (size == WORD && addr[1:0] != 2'b00))
      e.kind = KIND_MIS;
    else if (!allowed)
      e.kind = KIND_ERR;               // Unmapped too
    else if (addr == BUSERR_ADDR)
      e.kind = KIND_BUSERR;
    return e;
  endfunction

  function automatic logic [31:0] ram_word_addr();
    return 32'($random(seed)) & 32'h0000_03FC;   // Region 0, clear of BUSERR_ADDR
  endfunction

  function automatic biu_size_t pick_size();
    case ($unsigned($random(seed)) % 3)
      0:       return BYTE;
      1:       return HWORD;
      default: return WORD;
    endcase
  endfunction

  task automatic send_req(input logic [31:0] addr, input biu_size_t size, input logic we,
                          input logic [31:0] data);
    logic taken;
    mem_req_i           = 1'b1;
    mem_req_i_data.addr = addr;
    mem_req_i_data.size = size;
    mem_req_i_data.we   = we;
    mem_req_i_data.data = data;
    taken               = 1'b0;
    while (!taken)
    begin
      taken = mem_rdy_o;               // Holds until the next edge
      tick();
    end
    mem_req_i = 1'b0;
  endtask

  task automatic drain();
    while (pending.size() != 0)
      tick();
    repeat (3) tick();
  endtask

  // Bad access with good ones queued behind it
  task automatic fail_then_follow(input logic [31:0] addr, input biu_size_t size, input logic we);
    send_req(addr, size, we, $random(seed));
    send_req(ram_word_addr(), WORD, 1'b1, $random(seed));
    send_req(ram_word_addr(), WORD, 1'b1, $random(seed));
    drain();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, watchdog, bus model
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;        // 20 ns period
  end

  initial
  begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial
  begin : bus_model
    biu_req_t  breq;
    dmem_req_t front;
    expect_t   e;
    int        d0;
    int        d1;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    wait (rst_n_i);
    forever
    begin
      tick();
      biu_stb_ack_i = 1'b0;
      biu_ack_i     = 1'b0;
      biu_err_i     = 1'b0;
      if (biu_stb_o)
      begin
        breq = biu_req_o;
        if (pending.size() == 0)
          flag_problem("Bus strobe seen with no request outstanding");
        else
        begin
          front = pending[0];            // In flight request is the oldest
          e     = ref_model(front.addr, front.size, front.we, pma_cfg);
          if (e.kind == KIND_ERR || e.kind == KIND_MIS)
            flag_problem("Bus strobe raised for an access that fails its check");
          check_eq("biu_req_o.addr", breq.addr, front.addr);
          check_eq("biu_req_o.size", 32'(breq.size), 32'(front.size));
          check_eq("biu_req_o.we", 32'(breq.we), 32'(front.we));
          if (front.we)
            check_eq("biu_req_o.data", breq.data, front.data);
        end
        check_eq("biu_req_o.prot data bit", 32'(breq.prot[0]), 32'd1);
        check_eq("biu_req_o.prot privileged bit", 32'(breq.prot[1]), 32'(st_prv_i != PRV_U));
        d0 = $unsigned($random(seed)) % 3;
        repeat (d0) tick();
        biu_stb_ack_i = 1'b1;
        d1 = $unsigned($random(seed)) % 3;
        if (d1 != 0)                     // Zero means data ack with the address ack
        begin
          tick();
          biu_stb_ack_i = 1'b0;
          repeat (d1 - 1) tick();
        end
        if (breq.addr == BUSERR_ADDR)
          biu_err_i = 1'b1;
        else
        begin
          biu_ack_i = 1'b1;
          biu_q_i   = bus_mem.exists(breq.addr[31:2]) ? bus_mem[breq.addr[31:2]]
                                                      : fill_word(breq.addr);
          if (breq.we)
            bus_mem[breq.addr[31:2]] = merge_lanes(biu_q_i, breq.data, breq.addr, breq.size);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparing process, samples mid cycle
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : monitor
    dmem_req_t r;
    expect_t   e;
    forever
    begin
      @(negedge clk_i);
      if (rst_n_i)
      begin
        if (!mem_rdy_o)
          rdy_low++;
        if (mem_ack_o || mem_err_o)
        begin
          if (pending.size() == 0)
            flag_problem("Response seen with no request outstanding");
          else
          begin
            r = pending.pop_front();
            e = ref_model(r.addr, r.size, r.we, pma_cfg);
            responses++;
            check_eq("mem_ack_o", 32'(mem_ack_o), 32'(e.kind == KIND_ACK));
            check_eq("mem_err_o", 32'(mem_err_o), 32'(e.kind != KIND_ACK));
            check_eq("mem_misaligned_o", 32'(mem_misaligned_o), 32'(e.kind == KIND_MIS));
            if (e.kind == KIND_ACK && !r.we)
              check_eq("mem_q_o", mem_q_o, e.data);
            if (e.kind == KIND_ACK && r.we)
              shadow_mem[r.addr[31:2]] = merge_lanes(read_shadow(r.addr), r.data, r.addr, r.size);
            if (e.kind != KIND_ACK)
            begin
              discarded += pending.size();  // Flush empties the queue
              pending.delete();
            end
          end
        end
        if (mem_req_i && mem_rdy_o)
        begin
          if (mem_err_o)
            discarded++;                // Taken in the flush cycle
          else
            pending.push_back(mem_req_i_data);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    logic [31:0] addrs [$];
    logic [31:0] a;
    biu_size_t   sz;
    logic        w;
    logic [31:0] d;
    seed           = 69952;
    errors         = 0;
    checks         = 0;
    responses      = 0;
    discarded      = 0;
    rdy_low        = 0;
    mem_req_i      = 1'b0;
    mem_req_i_data = '0;
    st_prv_i       = PRV_M;
    pma_cfg[0]     = region(32'h0000_0000, 32'h0000_0FFF, 1'b1, 1'b1);  // RAM
    pma_cfg[1]     = region(32'h0000_1000, 32'h0000_1FFF, 1'b1, 1'b0);  // Read only
    pma_cfg[2]     = region(32'h0000_2000, 32'h0000_2FFF, 1'b0, 1'b1);  // Write only
    rst_n_i        = 1'b0;
    repeat (2) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    check_eq("mem_rdy_o", 32'(mem_rdy_o), 32'd1);
    check_eq("biu_stb_o", 32'(biu_stb_o), 32'd0);
    check_eq("mem_ack_o", 32'(mem_ack_o), 32'd0);
    check_eq("mem_err_o", 32'(mem_err_o), 32'd0);
    check_eq("mem_misaligned_o", 32'(mem_misaligned_o), 32'd0);

    // Word writes then reads back
    for (int k = 0; k < 40; k++)
    begin
      a = ram_word_addr();
      addrs.push_back(a);
      send_req(a, WORD, 1'b1, $random(seed));
    end
    foreach (addrs[i])
      send_req(addrs[i], WORD, 1'b0, 32'h0);
    drain();

    // Byte and halfword traffic
    for (int k = 0; k < 16; k++)
    begin
      a = 32'h0000_0400 + 32'(k);
      send_req(a, BYTE, 1'b1, $random(seed));
      if (k % 2 == 0)
        send_req(a, HWORD, 1'b0, 32'h0);
      send_req(a, BYTE, 1'b0, 32'h0);
    end
    drain();

    // User mode clears the privileged bit
    st_prv_i = PRV_U;
    for (int k = 0; k < 8; k++)
      send_req(ram_word_addr(), WORD, 1'($random(seed)), $random(seed));
    drain();
    st_prv_i = PRV_M;

    fail_then_follow(32'h0000_0101, HWORD, 1'b0);  // Misaligned half
    fail_then_follow(32'h0000_0106, WORD,  1'b1);  // Misaligned word
    fail_then_follow(32'h0000_1010, WORD,  1'b1);  // Store to read only
    fail_then_follow(32'h0000_2020, WORD,  1'b0);  // Load from write only
    fail_then_follow(32'h0000_8000, WORD,  1'b0);  // Unmapped
    fail_then_follow(BUSERR_ADDR,   WORD,  1'b0);
    send_req(32'h0000_1010, WORD, 1'b0, 32'h0);    // Legal sides of the same regions
    send_req(32'h0000_2020, WORD, 1'b1, $random(seed));
    drain();

    // Back to back under bus delays
    for (int k = 0; k < 30; k++)
      send_req(ram_word_addr(), WORD, 1'($random(seed)), $random(seed));
    drain();

    // Mixed traffic over mapped and unmapped space
    for (int k = 0; k < 50; k++)
    begin
      a  = 32'($random(seed)) & 32'h0000_3FFF;
      sz = pick_size();
      w  = 1'($random(seed));
      d  = $random(seed);
      send_req(a, sz, w, d);
    end
    drain();

    check_eq("requests dropped by flush seen", 32'(discarded != 0), 32'd1);
    check_eq("queue full seen", 32'(rdy_low != 0), 32'd1);
    $display("Checks: %0d  errors: %0d  responses: %0d  dropped: %0d",
             checks, errors, responses, discarded);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- bench/dmem_ext_if_props.sv
// Bound into dmem_ext_if; all properties are off while rst_n_i is low
`timescale 1ns/10ps

module dmem_ext_if_props (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               head_valid_i,
  input logic               check_err_i,
  input logic               biu_stb_o,
  input dmem_pkg::biu_req_t biu_req_o,
  input logic               biu_stb_ack_i,
  input logic               mem_ack_o,
  input logic               mem_err_o,
  input logic               mem_misaligned_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  // Strobe and request hold until the slave takes them
  stb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_req_o))
    else $error("biu_stb_o dropped or biu_req_o changed before biu_stb_ack_i");

  // Rejected head never reaches the bus
  no_stb_on_fail: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    head_valid_i && check_err_i |=> !$rose(biu_stb_o))
    else $error("biu_stb_o rose after a failed check");

  ////////////////////////////////////////////////////////////////////////////
  // CPU response
  ////////////////////////////////////////////////////////////////////////////

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mem_ack_o && mem_err_o))
    else $error("mem_ack_o and mem_err_o high together");

  mis_is_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_misaligned_o |-> mem_err_o)   // Misalignment is one kind of error
    else $error("mem_misaligned_o without mem_err_o");

endmodule

//--- verilog/dmem_ctrl.sv
// Uncached path only; no MMU so the CPU address goes straight to the BIU
`timescale 1ns/10ps

module dmem_ctrl #(
  parameter int DEPTH   = 2,     // Request queue entries
  parameter int PMA_CNT = 3      // Attribute regions
)
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Configuration
  input  dmem_pkg::pma_region_t           pma_cfg_i [PMA_CNT],

  // CPU side
  input  logic                            mem_req_i,
  input  dmem_pkg::dmem_req_t             mem_req_i_data,
  output logic                            mem_rdy_o,         // Queue not full
  output logic [dmem_pkg::DMEM_XLEN-1:0]  mem_q_o,
  output logic                            mem_ack_o,
  output logic                            mem_err_o,
  output logic                            mem_misaligned_o,

  input  logic [1:0]                      st_prv_i,

  // BIU
  output logic                            biu_stb_o,
  output dmem_pkg::biu_req_t              biu_req_o,
  input  logic                            biu_stb_ack_i,
  input  logic [dmem_pkg::DMEM_XLEN-1:0]  biu_q_i,
  input  logic                            biu_ack_i,
  input  logic                            biu_err_i
);

  import dmem_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Wires
  ////////////////////////////////////////////////////////////////////////////

  logic      head_valid;
  dmem_req_t head;
  logic      check_err;
  logic      check_misaligned;
  logic      pop;
  logic      flush;

  ////////////////////////////////////////////////////////////////////////////
  // Request queue
  ////////////////////////////////////////////////////////////////////////////

  dmem_req_fifo #(
    .DEPTH ( DEPTH      ),
    .T     ( dmem_req_t )
  )
  req_fifo_i (
    .clk_i        ( clk_i          ),
    .rst_n_i      ( rst_n_i        ),
    .push_i       ( mem_req_i      ),   // Gated by ready inside
    .push_data_i  ( mem_req_i_data ),
    .pop_i        ( pop            ),
    .flush_i      ( flush          ),
    .head_valid_o ( head_valid     ),
    .head_o       ( head           ),
    .ready_o      ( mem_rdy_o      )
  );

  // Alignment and attribute check on the head
  dmem_access_chk #(
    .PMA_CNT ( PMA_CNT )
  )
  access_chk_i (
    .head_i       ( head             ),
    .pma_cfg_i    ( pma_cfg_i        ),
    .err_o        ( check_err        ),
    .misaligned_o ( check_misaligned )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bus engine
  ////////////////////////////////////////////////////////////////////////////

  dmem_ext_if ext_if_i (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .head_valid_i       ( head_valid       ),
    .head_i             ( head             ),
    .check_err_i        ( check_err        ),
    .check_misaligned_i ( check_misaligned ),
    .st_prv_i           ( st_prv_i         ),
    .pop_o              ( pop              ),
    .flush_o            ( flush            ),
    .mem_q_o            ( mem_q_o          ),
    .mem_ack_o          ( mem_ack_o        ),
    .mem_err_o          ( mem_err_o        ),
    .mem_misaligned_o   ( mem_misaligned_o ),
    .biu_stb_o          ( biu_stb_o        ),
    .biu_req_o          ( biu_req_o        ),
    .biu_stb_ack_i      ( biu_stb_ack_i    ),
    .biu_ack_i          ( biu_ack_i        ),
    .biu_err_i          ( biu_err_i        ),
    .biu_q_i            ( biu_q_i          )
  );

endmodule

//--- verilog/dmem_ext_if.sv
// One single BIU transfer at a time; data ack may coincide with strobe ack; read data is not lane shifted
`timescale 1ns/10ps

module dmem_ext_if (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Queue head and its check
  input  logic                            head_valid_i,
  input  dmem_pkg::dmem_req_t             head_i,
  input  logic                            check_err_i,
  input  logic                            check_misaligned_i,
  input  logic [1:0]                      st_prv_i,          // Current privilege

  // Queue control
  output logic                            pop_o,
  output logic                            flush_o,

  // CPU response
  output logic [dmem_pkg::DMEM_XLEN-1:0]  mem_q_o,
  output logic                            mem_ack_o,
  output logic                            mem_err_o,
  output logic                            mem_misaligned_o,

  // BIU
  output logic                            biu_stb_o,
  output dmem_pkg::biu_req_t              biu_req_o,
  input  logic                            biu_stb_ack_i,
  input  logic                            biu_ack_i,
  input  logic                            biu_err_i,
  input  logic [dmem_pkg::DMEM_XLEN-1:0]  biu_q_i
);

  import dmem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,       // Wait for a head
    ST_STROBE,     // Address phase
    ST_WAIT,       // Data phase
    ST_RESP        // One cycle of response to the CPU
  } state_t;

  state_t               state;
  logic                 resp_err;     // Response is an error
  logic                 resp_mis;     // Error was misalignment
  biu_req_t             req_q;        // Held while strobing
  logic [DMEM_XLEN-1:0] q_q;          // Read data
  biu_prot_t            prot;
  logic                 issue;
  logic                 reject;
  logic                 data_phase;
  logic                 xfer_done;
  logic                 resp;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign prot = PROT_DATA | ((st_prv_i == PRV_U) ? biu_prot_t'(0) : PROT_PRIVILEGED);

  assign issue  = (state == ST_IDLE) & head_valid_i & ~check_err_i;  // Start a transfer
  assign reject = (state == ST_IDLE) & head_valid_i &  check_err_i;  // Answer with error

  // Data ack counts once the address is taken
  assign data_phase = (state == ST_WAIT) | ((state == ST_STROBE) & biu_stb_ack_i);
  assign xfer_done  = data_phase & (biu_ack_i | biu_err_i);

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state    <= ST_IDLE;
      resp_err <= 1'b0;
      resp_mis <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (reject)
          begin
            state    <= ST_RESP;
            resp_err <= 1'b1;
            resp_mis <= check_misaligned_i;
          end
          else if (issue)
          begin
            state    <= ST_STROBE;
            resp_err <= 1'b0;
            resp_mis <= 1'b0;
          end
        end

        ST_STROBE:
        begin
          if (xfer_done)                  // Both acks in one cycle
          begin
            state    <= ST_RESP;
            resp_err <= biu_err_i;
          end
          else if (biu_stb_ack_i)
            state <= ST_WAIT;
        end

        ST_WAIT:
        begin
          if (xfer_done)
          begin
            state    <= ST_RESP;
            resp_err <= biu_err_i;          // Bus error flushes too
          end
        end

        default: state <= ST_IDLE;         // ST_RESP lasts one cycle
      endcase
    end
  end

  // Request and read data registers
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      req_q.addr <= head_i.addr;
      req_q.size <= head_i.size;
      req_q.prot <= prot;                   // Privilege sampled at issue
      req_q.we   <= head_i.we;
      req_q.data <= head_i.data;
    end
    if (data_phase && biu_ack_i)
      q_q <= biu_q_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign resp = (state == ST_RESP);

  assign biu_stb_o = (state == ST_STROBE);
  assign biu_req_o = req_q;

  assign pop_o   = resp;                  // Head done either way
  assign flush_o = resp & resp_err;       // Drop everything queued behind an error

  assign mem_q_o          = q_q;
  assign mem_ack_o        = resp & ~resp_err;
  assign mem_err_o        = resp &  resp_err;
  assign mem_misaligned_o = resp &  resp_mis;

endmodule

//--- verilog/dmem_access_chk.sv
// Purely combinational; only the start address is matched against regions, not the last byte
`timescale 1ns/10ps

module dmem_access_chk #(
  parameter int PMA_CNT = 3      // Number of attribute regions
)
(
  input  dmem_pkg::dmem_req_t   head_i,              // Queue head
  input  dmem_pkg::pma_region_t pma_cfg_i [PMA_CNT], // Region table, index 0 first
  output logic                  err_o,               // Any failure
  output logic                  misaligned_o         // Alignment failure only
);

  import dmem_pkg::*;

  logic [PMA_CNT-1:0] in_range;      // Per region hit
  logic               region_hit;    // Some region holds the address
  logic               region_rd;     // Permissions of the deciding region
  logic               region_wr;
  logic               perm_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (head_i.size)
      HWORD:   misaligned_o = head_i.addr[0];
      WORD:    misaligned_o = |head_i.addr[1:0];
      default: misaligned_o = 1'b0;          // Bytes always fit
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Region match
  ////////////////////////////////////////////////////////////////////////////

  // Range compare for every region in parallel
  always_comb
  begin
    for (int i = 0; i < PMA_CNT; i++)
    begin
      in_range[i] = pma_cfg_i[i].valid &&
                    (head_i.addr >= pma_cfg_i[i].lo) &&
                    (head_i.addr <= pma_cfg_i[i].hi);
    end
  end

  // Lowest index wins when regions overlap
  always_comb
  begin
    region_hit = 1'b0;
    region_rd  = 1'b0;
    region_wr  = 1'b0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      if (in_range[i] && !region_hit)
      begin
        region_hit = 1'b1;
        region_rd  = pma_cfg_i[i].readable;
        region_wr  = pma_cfg_i[i].writable;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Permission and result
  ////////////////////////////////////////////////////////////////////////////

  // Store needs writable, load needs readable
  assign perm_ok = head_i.we ? region_wr : region_rd;

  // Unmapped addresses fail through region_hit
  assign err_o = misaligned_o | ~region_hit | ~perm_ok;

endmodule

//--- verilog/dmem_req_fifo.sv
// Push is refused while full even with a pop in the same cycle; flush also drops a same-cycle push
`timescale 1ns/10ps

module dmem_req_fifo #(
  parameter int  DEPTH = 2,      // Entries, any value from 1 up
  parameter type T     = logic   // Payload
)
(
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic push_i,
  input  T     push_data_i,

  input  logic pop_i,
  input  logic flush_i,          // Empties the buffer, wins over push and pop

  output logic head_valid_o,
  output T     head_o,
  output logic ready_o           // Not full
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
  localparam int CW = $clog2(DEPTH + 1);                // Fill count width

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  T              mem [DEPTH];    // Payload only
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] cnt;            // Entries in use
  logic          do_push;
  logic          do_pop;

  // Wrap at DEPTH so odd depths work too
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    if (p == PW'(DEPTH - 1))
      return '0;
    return p + PW'(1);
  endfunction

  assign ready_o      = (cnt != CW'(DEPTH));
  assign head_valid_o = (cnt != '0);
  assign head_o       = mem[rd_ptr];   // Registered storage, valid a cycle after push

  assign do_push = push_i & ready_o;         // Ignore pushes when full
  assign do_pop  = pop_i  & head_valid_o;    // And pops when empty

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else if (flush_i)
    begin
      // Drop everything and this cycle's push
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);

      case ({do_push, do_pop})
        2'b10:   cnt <= cnt + CW'(1);
        2'b01:   cnt <= cnt - CW'(1);
        default: cnt <= cnt;           // Both or neither
      endcase
    end
  end

  // Payload write
  always_ff @(posedge clk_i)
  begin
    if (do_push && !flush_i)
      mem[wr_ptr] <= push_data_i;
  end

endmodule

//--- verilog/dmem_pkg.sv
// Address and data width fixed at 32 bits here and not overridable per instance; sizes up to WORD only
package dmem_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////////////

  localparam int DMEM_XLEN = 32;  // Address and data width

  //////////////////////////////////////////////////////////////////////////////
  // BIU encodings
  //////////////////////////////////////////////////////////////////////////////

  // Transfer size, no DWORD on a 32 bit bus
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } biu_size_t;

  typedef logic [2:0] biu_prot_t;  // Bit 2 unused here

  localparam biu_prot_t PROT_DATA       = 3'b001;  // Data, not instruction
  localparam biu_prot_t PROT_PRIVILEGED = 3'b010;  // Privileged, clear for user

  // Privilege levels as seen on st_prv_i
  localparam logic [1:0] PRV_U = 2'b00;
  localparam logic [1:0] PRV_M = 2'b11;

  //////////////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////////////

  // CPU request as held in the queue
  typedef struct packed {
    logic [DMEM_XLEN-1:0] addr;  // Physical, no translation
    biu_size_t            size;
    logic                 we;    // Store when set
    logic [DMEM_XLEN-1:0] data;  // Store data, ignored on loads
  } dmem_req_t;

  // Request fields driven on the BIU while biu_stb_o is high
  typedef struct packed {
    logic [DMEM_XLEN-1:0] addr;
    biu_size_t            size;
    biu_prot_t            prot;
    logic                 we;
    logic [DMEM_XLEN-1:0] data;  // Passed as is, no lane steering
  } biu_req_t;

  // One attribute region
  // Bounds are inclusive on both ends
  typedef struct packed {
    logic                 valid;     // Region takes part in matching
    logic [DMEM_XLEN-1:0] lo;        // Lowest address
    logic [DMEM_XLEN-1:0] hi;        // Highest address
    logic                 readable;
    logic                 writable;
  } pma_region_t;

endpackage
